/* Makefile */
# Verilator build and run for the debug ring system

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert
TOP       := tb_dbg_ring_system
FILELIST  := project.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
LOG       := sim.log
PASS_MSG  := ALL CHECKS PASSED

SOURCES := $(wildcard verilog/*.sv verilog/*.svh tests/*.sv)

.PHONY: all build run clean

all: run

build: $(SIM)

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	./$(SIM) 2>&1 | tee $(LOG)
	@grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* project.f */
+incdir+verilog
verilog/dbg_ring_pkg.sv
verilog/dbg_host_if.sv
verilog/dbg_ring_node.sv
verilog/dbg_ring_collector.sv
verilog/dbg_ring_system.sv
tests/dbg_ring_asserts.sv
tests/tb_dbg_ring_system.sv

/* tests/dbg_ring_asserts.sv */
/* debug ring host port assertions
 *  - idle state after reset
 *  - response held stable while the host stalls
 *  - no unknown handshake or response values
 *  - count of failed assertions
 */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_ring_consts.svh"

module dbg_ring_asserts (
   input logic                   clk,
   input logic                   rst_n_i,
   input logic                   cmd_ready_i,
   input logic                   resp_valid_i,
   input logic                   resp_ready_i,
   input logic [`DBG_ID_W-1:0]   resp_src_i,
   input logic                   resp_err_i,
   input logic [`DBG_DATA_W-1:0] resp_data_i
   );

   int fail_cnt = 0;   // assertion failures so far

   a_reset_idle : assert property (@(posedge clk)
      !rst_n_i |=> !resp_valid_i && cmd_ready_i)
      else begin
         fail_cnt++;
         $error("host port not idle after reset");
      end

   a_resp_hold : assert property (@(posedge clk) disable iff (!rst_n_i)
      resp_valid_i && !resp_ready_i |=> resp_valid_i && $stable(resp_src_i)
                                        && $stable(resp_err_i) && $stable(resp_data_i))
      else begin
         fail_cnt++;
         $error("response changed or dropped while stalled");
      end

   a_hs_known : assert property (@(posedge clk) disable iff (!rst_n_i)
      !$isunknown(cmd_ready_i) && !$isunknown(resp_valid_i))
      else begin
         fail_cnt++;
         $error("unknown value on a host handshake");
      end

   a_resp_known : assert property (@(posedge clk) disable iff (!rst_n_i)
      resp_valid_i |-> !$isunknown({resp_src_i, resp_err_i, resp_data_i}))
      else begin
         fail_cnt++;
         $error("unknown value in a valid response");
      end

endmodule

bind dbg_ring_system dbg_ring_asserts u_asserts (
   .clk          (clk),
   .rst_n_i      (rst_n_i),
   .cmd_ready_i  (cmd_ready_o),
   .resp_valid_i (resp_valid_o),
   .resp_ready_i (resp_ready_i),
   .resp_src_i   (resp_src_o),
   .resp_err_i   (resp_err_o),
   .resp_data_i  (resp_data_o)
);

`default_nettype wire

/* tests/tb_dbg_ring_system.sv */
/* debug ring system testbench
 *  - table of host commands applied in a loop
 *  - reference memory model and response scoreboard
 *  - random host back-pressure and latency check
 */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_ring_consts.svh"

module tb_dbg_ring_system
   import dbg_ring_pkg::*;
   ();

   localparam int NODES    = `DBG_NODES;
   localparam int MAX_CMDS = 256;

   typedef struct packed {
      logic                   write;
      logic [`DBG_ID_W-1:0]   dest;
      logic [`DBG_ADDR_W-1:0] addr;
      logic [`DBG_DATA_W-1:0] data;
      logic                   rand_ready;   // host stalls the response port at random
      logic                   timed;        // issued into an empty ring, latency checked
   } cmd_t;

   typedef struct packed {
      logic [`DBG_ID_W-1:0]   src;
      logic                   err;
      logic [`DBG_DATA_W-1:0] data;
      logic                   timed;
      logic [31:0]            accept_cyc;
   } exp_t;

   logic                   clk;
   logic                   rst_n_i;
   logic                   cmd_valid_i;
   logic                   cmd_ready_o;
   logic                   cmd_write_i;
   logic [`DBG_ID_W-1:0]   cmd_dest_i;
   logic [`DBG_ADDR_W-1:0] cmd_addr_i;
   logic [`DBG_DATA_W-1:0] cmd_wdata_i;
   logic                   resp_valid_o;
   logic                   resp_ready_i;
   logic [`DBG_ID_W-1:0]   resp_src_o;
   logic                   resp_err_o;
   logic [`DBG_DATA_W-1:0] resp_data_o;

   cmd_t                   cmd_table [0:MAX_CMDS-1];
   exp_t                   exp_q [$];
   logic [`DBG_DATA_W-1:0] ref_mem [0:15][0:`DBG_MEM_WORDS-1];   // indexed by node id
   int                     n_cmds      = 0;
   int                     err_cnt     = 0;
   int                     chk_cnt     = 0;
   int                     cycle_cnt   = 0;
   int                     cycle_limit = 0;
   logic                   rand_ready  = 1'b0;

   dbg_ring_system u_dbg_ring_system (
      .clk          (clk),
      .rst_n_i      (rst_n_i),
      .cmd_valid_i  (cmd_valid_i),
      .cmd_ready_o  (cmd_ready_o),
      .cmd_write_i  (cmd_write_i),
      .cmd_dest_i   (cmd_dest_i),
      .cmd_addr_i   (cmd_addr_i),
      .cmd_wdata_i  (cmd_wdata_i),
      .resp_valid_o (resp_valid_o),
      .resp_ready_i (resp_ready_i),
      .resp_src_o   (resp_src_o),
      .resp_err_o   (resp_err_o),
      .resp_data_o  (resp_data_o)
   );

   initial begin
      clk = 1'b0;
      forever #50 clk = ~clk;   // 100 ns period
   end

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_limit > 0 && cycle_cnt >= cycle_limit) begin
         $display("ERROR: timeout after %0d cycles with %0d responses outstanding",
                  cycle_cnt, exp_q.size());
         $display("checks %0d errors %0d", chk_cnt,
                  err_cnt + u_dbg_ring_system.u_asserts.fail_cnt + 1);
         $display("CHECKS FAILED");
         $finish;
      end
   end

   always @(negedge clk) begin
      resp_ready_i <= rand_ready ? 1'($urandom) : 1'b1;
   end

   task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
      chk_cnt++;
      if (got !== exp) begin
         err_cnt++;
         $display("MISMATCH t=%0t %s got 0x%08h expected 0x%08h", $time, name, got, exp);
      end
   endtask

   task automatic add_cmd(input logic write, input logic [`DBG_ID_W-1:0] dest,
                          input logic [`DBG_ADDR_W-1:0] addr, input logic [31:0] data,
                          input logic rnd, input logic timed);
      cmd_table[n_cmds] = {write, dest, addr, data, rnd, timed};
      n_cmds++;
   endtask

   // reference model, also records writes
   function automatic exp_t predict_response(input cmd_t c);
      exp_t e;
      e       = '0;
      e.src   = c.dest;
      e.timed = c.timed;
      if (int'(c.dest) == 0 || int'(c.dest) > NODES) begin
         e.err = 1'b1;                                 // no such tile
      end else if (c.write) begin
         ref_mem[c.dest][c.addr] = c.data;
         e.data                  = c.data;
      end else begin
         e.data = ref_mem[c.dest][c.addr];
      end
      return e;
   endfunction

   task automatic build_table();
      int n;
      for (n = 1; n <= NODES; n++) begin               // untouched registers
         add_cmd(1'b0, 4'(n), 4'd0, '0, 1'b0, 1'b0);
         add_cmd(1'b0, 4'(n), 4'd15, '0, 1'b0, 1'b0);
      end
      for (n = 1; n <= NODES; n++) begin               // write then read each tile
         add_cmd(1'b1, 4'(n), 4'(n), $urandom, 1'b0, 1'b0);
         add_cmd(1'b0, 4'(n), 4'(n), '0, 1'b0, 1'b0);
      end
      for (n = 1; n <= NODES; n++) begin               // same address in every tile
         add_cmd(1'b1, 4'(n), 4'd9, $urandom, 1'b0, 1'b0);
      end
      for (n = 1; n <= NODES; n++) begin
         add_cmd(1'b0, 4'(n), 4'd9, '0, 1'b0, 1'b0);
      end
      add_cmd(1'b1, 4'd0, 4'd9, $urandom, 1'b0, 1'b0);          // nonexistent ids
      add_cmd(1'b1, 4'(NODES + 1), 4'd9, $urandom, 1'b0, 1'b0);
      add_cmd(1'b0, 4'd15, 4'd0, '0, 1'b0, 1'b0);
      for (n = 1; n <= NODES; n++) begin
         add_cmd(1'b0, 4'(n), 4'd9, '0, 1'b0, 1'b0);
      end
      for (n = 0; n < 48; n++) begin                   // back to back under stalls
         add_cmd(1'($urandom), 4'($urandom_range(0, NODES + 1)), 4'($urandom),
                 $urandom, 1'b1, 1'b0);
      end
      add_cmd(1'b0, 4'(NODES), 4'd9, '0, 1'b0, 1'b1);
      add_cmd(1'b1, 4'd1, 4'd3, $urandom, 1'b0, 1'b1);
   endtask

   // let every outstanding response drain before a timed command
   task automatic wait_idle();
      @(negedge clk);
      cmd_valid_i = 1'b0;
      rand_ready  = 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
   endtask

   task automatic issue(input cmd_t c);
      exp_t e;
      @(negedge clk);
      rand_ready  = c.rand_ready;
      cmd_valid_i = 1'b1;
      cmd_write_i = c.write;
      cmd_dest_i  = c.dest;
      cmd_addr_i  = c.addr;
      cmd_wdata_i = c.data;
      @(posedge clk);
      while (!cmd_ready_o) @(posedge clk);
      e            = predict_response(c);
      e.accept_cyc = cycle_cnt;
      exp_q.push_back(e);
   endtask

   always @(posedge clk) begin : resp_monitor
      exp_t e;
      if (rst_n_i && resp_valid_o && resp_ready_i) begin
         if (exp_q.size() == 0) begin
            err_cnt++;
            $display("ERROR: t=%0t response from node %0d with no command outstanding",
                     $time, resp_src_o);
         end else begin
            e = exp_q.pop_front();
            check("resp_src_o", 32'(resp_src_o), 32'(e.src));
            check("resp_err_o", 32'(resp_err_o), 32'(e.err));
            check("resp_data_o", resp_data_o, e.data);
            if (e.timed) begin
               check("latency", cycle_cnt - e.accept_cyc, NODES + 2);
            end
         end
      end
   end

   initial begin
      int i;
      int a;
      int n;
      void'($urandom(32'h970a717d));
      rst_n_i      = 1'b0;
      cmd_valid_i  = 1'b0;
      cmd_write_i  = 1'b0;
      cmd_dest_i   = '0;
      cmd_addr_i   = '0;
      cmd_wdata_i  = '0;
      resp_ready_i = 1'b1;
      for (n = 0; n < 16; n++) begin
         for (a = 0; a < `DBG_MEM_WORDS; a++) begin
            ref_mem[n][a] = '0;
         end
      end
      build_table();
      cycle_limit = n_cmds * (NODES + 8) * 4;

      repeat (4) @(negedge clk);
      rst_n_i = 1'b1;
      @(posedge clk);
      check("resp_valid_o", 32'(resp_valid_o), 32'd0);   // idle after reset
      check("cmd_ready_o", 32'(cmd_ready_o), 32'd1);

      for (i = 0; i < n_cmds; i++) begin
         if (cmd_table[i].timed) begin
            wait_idle();
         end
         issue(cmd_table[i]);
      end
      @(negedge clk);
      cmd_valid_i = 1'b0;
      while (exp_q.size() != 0) @(posedge clk);
      repeat (4) @(posedge clk);
      check("resp_valid_o", 32'(resp_valid_o), 32'd0);   // nothing duplicated

      err_cnt = err_cnt + u_dbg_ring_system.u_asserts.fail_cnt;
      $display("checks %0d errors %0d", chk_cnt, err_cnt);
      if (err_cnt == 0) begin
         $display("ALL CHECKS PASSED");
      end else begin
         $display("CHECKS FAILED");
      end
      $finish;
   end

endmodule

`default_nettype wire

/* verilog/dbg_host_if.sv */
/* debug host interface
 *  - accepts read and write commands from the host port
 *  - builds a request flit with src 0 for each command
 *  - holds it in an output register until the first tile takes it
 */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_ring_consts.svh"

module dbg_host_if
   import dbg_ring_pkg::*;
   (
   input  logic                   clk,
   input  logic                   rst_n_i,

   input  logic                   cmd_valid_i,
   output logic                   cmd_ready_o,
   input  logic                   cmd_write_i,
   input  logic [`DBG_ID_W-1:0]   cmd_dest_i,
   input  logic [`DBG_ADDR_W-1:0] cmd_addr_i,
   input  logic [`DBG_DATA_W-1:0] cmd_wdata_i,

   output dbg_flit_t              ring_out_flit_o,
   output logic                   ring_out_valid_o,
   input  logic                   ring_out_ready_i
   );

   dbg_flit_t req_flit;
   dbg_flit_t flit_q;
   logic      valid_q;
   logic      cmd_fire;

   assign cmd_ready_o = ~valid_q | ring_out_ready_i;   // slot empty or leaving now
   assign cmd_fire    = cmd_valid_i & cmd_ready_o;

   always_comb begin
      req_flit      = '0;
      req_flit.dest = cmd_dest_i;
      req_flit.src  = '0;                               // host
      req_flit.op   = cmd_write_i ? DBG_OP_WRITE : DBG_OP_READ;
      req_flit.err  = 1'b0;
      req_flit.addr = cmd_addr_i;
      req_flit.data = cmd_write_i ? cmd_wdata_i : '0;   // reads carry no data
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else if (cmd_fire) begin
         valid_q <= 1'b1;
      end else if (ring_out_ready_i) begin
         valid_q <= 1'b0;                               // first tile took it
      end
   end

   // load only on accept so the flit stays stable while stalled
   always_ff @(posedge clk) begin
      if (cmd_fire) begin
         flit_q <= req_flit;
      end
   end

   assign ring_out_flit_o  = flit_q;
   assign ring_out_valid_o = valid_q;

endmodule

`default_nettype wire

/* verilog/dbg_ring_collector.sv */
/* debug ring collector
 *  - single drain at the end of the debug ring
 *  - passes response flits on to the host response port
 *  - turns unclaimed requests into error responses
 *  - output register holds the response under host back-pressure
 */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_ring_consts.svh"

module dbg_ring_collector
   import dbg_ring_pkg::*;
   (
   input  logic                   clk,
   input  logic                   rst_n_i,

   input  dbg_flit_t              ring_in_flit_i,
   input  logic                   ring_in_valid_i,
   output logic                   ring_in_ready_o,

   output logic                   resp_valid_o,
   input  logic                   resp_ready_i,
   output logic [`DBG_ID_W-1:0]   resp_src_o,
   output logic                   resp_err_o,
   output logic [`DBG_DATA_W-1:0] resp_data_o
   );

   logic                   valid_q;
   logic [`DBG_ID_W-1:0]   src_q;
   logic                   err_q;
   logic [`DBG_DATA_W-1:0] data_q;
   logic                   in_fire;
   logic                   unclaimed;

   assign ring_in_ready_o = ~valid_q | resp_ready_i;   // stall goes back up the ring
   assign in_fire         = ring_in_valid_i & ring_in_ready_o;

   // a request that got this far matched no tile
   assign unclaimed = (ring_in_flit_i.op != DBG_OP_RESP);

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         valid_q <= 1'b0;
      end else if (in_fire) begin
         valid_q <= 1'b1;
      end else if (resp_ready_i) begin
         valid_q <= 1'b0;
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire) begin
         src_q  <= unclaimed ? ring_in_flit_i.dest : ring_in_flit_i.src;
         err_q  <= unclaimed | ring_in_flit_i.err;
         data_q <= unclaimed ? '0 : ring_in_flit_i.data;
      end
   end

   assign resp_valid_o = valid_q;
   assign resp_src_o   = src_q;
   assign resp_err_o   = err_q;
   assign resp_data_o  = data_q;

endmodule

`default_nettype wire

/* verilog/dbg_ring_consts.svh */
/* debug ring constants
 *  - tile grid dimensions and node count
 *  - node id, register address and data widths
 *  - words per tile register memory
 */
`ifndef DBG_RING_CONSTS_SVH
`define DBG_RING_CONSTS_SVH

// tile grid
`define DBG_XDIM       3
`define DBG_YDIM       2
`define DBG_NODES      (`DBG_XDIM * `DBG_YDIM)

// flit fields, id 0 is the host and tiles use ids 1 to 15
`define DBG_ID_W       4
`define DBG_ADDR_W     4
`define DBG_DATA_W     32

// per tile register memory, one word per address
`define DBG_MEM_WORDS  16

`endif

/* verilog/dbg_ring_node.sv */
/* debug ring tile node
 *  - one register stage of the debug ring
 *  - local register memory of DBG_MEM_WORDS words
 *  - turns requests addressed to NODE_ID into responses in the same slot
 *  - passes all other flits through unchanged
 */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_ring_consts.svh"

module dbg_ring_node
   import dbg_ring_pkg::*;
   #(
   parameter logic [`DBG_ID_W-1:0] NODE_ID = 1
   )
   (
   input  logic      clk,
   input  logic      rst_n_i,

   input  dbg_flit_t ring_in_flit_i,
   input  logic      ring_in_valid_i,
   output logic      ring_in_ready_o,

   output dbg_flit_t ring_out_flit_o,
   output logic      ring_out_valid_o,
   input  logic      ring_out_ready_i
   );

   logic [`DBG_DATA_W-1:0]    mem [0:`DBG_MEM_WORDS-1];
   logic [`DBG_MEM_WORDS-1:0] written_q;   // words stored since reset
   logic [`DBG_DATA_W-1:0]    rd_word;

   dbg_flit_t flit_q;
   dbg_flit_t next_flit;
   logic      valid_q;
   logic      in_fire;
   logic      is_req;
   logic      hit;
   logic      wr_hit;

   assign ring_in_ready_o = ~valid_q | ring_out_ready_i;   // empty or draining
   assign in_fire         = ring_in_valid_i & ring_in_ready_o;

   assign is_req = (ring_in_flit_i.op == DBG_OP_READ) | (ring_in_flit_i.op == DBG_OP_WRITE);
   assign hit    = is_req & (ring_in_flit_i.dest == NODE_ID);
   assign wr_hit = in_fire & hit & (ring_in_flit_i.op == DBG_OP_WRITE);

   // untouched words read as zero without clearing the whole array
   assign rd_word = written_q[ring_in_flit_i.addr] ? mem[ring_in_flit_i.addr] : '0;

   always_comb begin
      next_flit = ring_in_flit_i;
      if (hit) begin
         next_flit.dest = '0;                               // back to the host
         next_flit.src  = NODE_ID;
         next_flit.op   = DBG_OP_RESP;
         next_flit.err  = 1'b0;
         if (ring_in_flit_i.op == DBG_OP_READ) begin
            next_flit.data = rd_word;
         end
         // a write echoes the data it stored
      end
   end

   always_ff @(posedge clk) begin
      if (!rst_n_i) begin
         valid_q   <= 1'b0;
         written_q <= '0;
      end else begin
         if (in_fire) begin
            valid_q <= 1'b1;
         end else if (ring_out_ready_i) begin
            valid_q <= 1'b0;
         end
         if (wr_hit) begin
            written_q[ring_in_flit_i.addr] <= 1'b1;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (in_fire) begin
         flit_q <= next_flit;
      end
      if (wr_hit) begin
         mem[ring_in_flit_i.addr] <= ring_in_flit_i.data;
      end
   end

   assign ring_out_flit_o  = flit_q;
   assign ring_out_valid_o = valid_q;

endmodule

`default_nettype wire

/* verilog/dbg_ring_pkg.sv */
/* debug ring types
 *  - ring opcode enum
 *  - single flit packet struct
 */
`default_nettype none
`include "dbg_ring_consts.svh"

package dbg_ring_pkg;

   typedef enum logic [1:0] {
      DBG_OP_READ  = 2'd0,   // read request
      DBG_OP_WRITE = 2'd1,   // write request
      DBG_OP_RESP  = 2'd2    // response back to the host
   } dbg_op_e;

   // every packet on the ring is exactly one of these
   typedef struct packed {
      logic [`DBG_ID_W-1:0]   dest;   // destination node id
      logic [`DBG_ID_W-1:0]   src;    // sender node id
      dbg_op_e                op;
      logic                   err;    // set on error
      logic [`DBG_ADDR_W-1:0] addr;   // register address
      logic [`DBG_DATA_W-1:0] data;
   } dbg_flit_t;

endpackage

`default_nettype wire

/* verilog/dbg_ring_system.sv */
/* debug ring system top level
 *  - host interface at the ring start
 *  - grid of DBG_XDIM x DBG_YDIM tile nodes
 *  - meander ring wiring, even rows left to right, odd rows right to left
 *  - collector at the ring end feeding the host response port
 */
`timescale 1ns/1ps
`default_nettype none
`include "dbg_ring_consts.svh"

module dbg_ring_system
   import dbg_ring_pkg::*;
   (
   input  logic                   clk,
   input  logic                   rst_n_i,

   input  logic                   cmd_valid_i,
   output logic                   cmd_ready_o,
   input  logic                   cmd_write_i,
   input  logic [`DBG_ID_W-1:0]   cmd_dest_i,
   input  logic [`DBG_ADDR_W-1:0] cmd_addr_i,
   input  logic [`DBG_DATA_W-1:0] cmd_wdata_i,

   output logic                   resp_valid_o,
   input  logic                   resp_ready_i,
   output logic [`DBG_ID_W-1:0]   resp_src_o,
   output logic                   resp_err_o,
   output logic [`DBG_DATA_W-1:0] resp_data_o
   );

   localparam int XDIM  = `DBG_XDIM;
   localparam int YDIM  = `DBG_YDIM;
   localparam int NODES = `DBG_NODES;

   // links indexed by grid position, in side and out side of each tile
   dbg_flit_t node_in_flit   [0:NODES-1];
   logic      node_in_valid  [0:NODES-1];
   logic      node_in_ready  [0:NODES-1];
   dbg_flit_t node_out_flit  [0:NODES-1];
   logic      node_out_valid [0:NODES-1];
   logic      node_out_ready [0:NODES-1];

   dbg_flit_t last_flit;   // ring end into the collector
   logic      last_valid;
   logic      last_ready;

   dbg_host_if u_host (
      .clk              (clk),
      .rst_n_i          (rst_n_i),
      .cmd_valid_i      (cmd_valid_i),
      .cmd_ready_o      (cmd_ready_o),
      .cmd_write_i      (cmd_write_i),
      .cmd_dest_i       (cmd_dest_i),
      .cmd_addr_i       (cmd_addr_i),
      .cmd_wdata_i      (cmd_wdata_i),
      .ring_out_flit_o  (node_in_flit[0]),
      .ring_out_valid_o (node_in_valid[0]),
      .ring_out_ready_i (node_in_ready[0])
   );

   genvar x, y;
   generate
      for (y = 0; y < YDIM; y++) begin : gen_row
         for (x = 0; x < XDIM; x++) begin : gen_col
            localparam int IDX = y * XDIM + x;

            dbg_ring_node #(
               .NODE_ID (`DBG_ID_W'(IDX + 1))   // id 0 belongs to the host
            ) u_node (
               .clk              (clk),
               .rst_n_i          (rst_n_i),
               .ring_in_flit_i   (node_in_flit[IDX]),
               .ring_in_valid_i  (node_in_valid[IDX]),
               .ring_in_ready_o  (node_in_ready[IDX]),
               .ring_out_flit_o  (node_out_flit[IDX]),
               .ring_out_valid_o (node_out_valid[IDX]),
               .ring_out_ready_i (node_out_ready[IDX])
            );

            if (IDX > 0) begin : gen_link
               if (y % 2 == 0) begin : gen_even
                  if (x == 0) begin : gen_turn
                     // row start fed from the left end of the odd row above
                     assign node_in_flit[IDX]             = node_out_flit[(y-1)*XDIM];
                     assign node_in_valid[IDX]            = node_out_valid[(y-1)*XDIM];
                     assign node_out_ready[(y-1)*XDIM]    = node_in_ready[IDX];
                  end else begin : gen_step
                     assign node_in_flit[IDX]      = node_out_flit[IDX-1];
                     assign node_in_valid[IDX]     = node_out_valid[IDX-1];
                     assign node_out_ready[IDX-1]  = node_in_ready[IDX];
                  end
               end else begin : gen_odd
                  if (x == XDIM - 1) begin : gen_turn
                     // right end fed from the right end of the even row above
                     assign node_in_flit[IDX]         = node_out_flit[IDX-XDIM];
                     assign node_in_valid[IDX]        = node_out_valid[IDX-XDIM];
                     assign node_out_ready[IDX-XDIM]  = node_in_ready[IDX];
                  end else begin : gen_step
                     assign node_in_flit[IDX]      = node_out_flit[IDX+1];
                     assign node_in_valid[IDX]     = node_out_valid[IDX+1];
                     assign node_out_ready[IDX+1]  = node_in_ready[IDX];
                  end
               end
            end
         end
      end

      // the meander ends at the left edge for an even row count
      if (YDIM % 2 == 0) begin : gen_last_left
         assign last_flit                   = node_out_flit[NODES-XDIM];
         assign last_valid                  = node_out_valid[NODES-XDIM];
         assign node_out_ready[NODES-XDIM]  = last_ready;
      end else begin : gen_last_right
         assign last_flit               = node_out_flit[NODES-1];
         assign last_valid              = node_out_valid[NODES-1];
         assign node_out_ready[NODES-1] = last_ready;
      end
   endgenerate

   dbg_ring_collector u_collector (
      .clk             (clk),
      .rst_n_i         (rst_n_i),
      .ring_in_flit_i  (last_flit),
      .ring_in_valid_i (last_valid),
      .ring_in_ready_o (last_ready),
      .resp_valid_o    (resp_valid_o),
      .resp_ready_i    (resp_ready_i),
      .resp_src_o      (resp_src_o),
      .resp_err_o      (resp_err_o),
      .resp_data_o     (resp_data_o)
   );

endmodule

`default_nettype wire
